// ==== riscv.f ====
+incdir+bench
design/riscv_pkg.sv
design/riscv_fetch.sv
design/riscv_decode.sv
design/riscv_regfile.sv
design/riscv_execute.sv
design/riscv_commit.sv
design/riscv.sv
bench/tb_riscv.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_riscv
RTL_TOP   := riscv
FLIST     := riscv.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "\*\*\* PASSED \*\*\*" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/riscv_iss.svh ====
`ifndef RISCV_ISS_SVH
`define RISCV_ISS_SVH

localparam logic [31:0] SELF_LOOP = 32'h0000_006f;

function automatic logic [31:0] size_extend(input logic [31:0] raw,
                                            input riscv_pkg::ldst_mode_t mode);
  case (mode)
    riscv_pkg::BYTE:   return {{24{raw[7]}}, raw[7:0]};
    riscv_pkg::HALF:   return {{16{raw[15]}}, raw[15:0]};
    riscv_pkg::BYTE_U: return {24'd0, raw[7:0]};
    riscv_pkg::HALF_U: return {16'd0, raw[15:0]};
    default:           return raw;
  endcase
endfunction

function automatic int byte_count(input riscv_pkg::ldst_mode_t mode);
  case (mode)
    riscv_pkg::BYTE, riscv_pkg::BYTE_U: return 1;
    riscv_pkg::HALF, riscv_pkg::HALF_U: return 2;
    default:                            return 4;
  endcase
endfunction

function automatic riscv_pkg::ldst_mode_t mode_of(input logic [2:0] f3);
  case (f3)
    3'd0:    return riscv_pkg::BYTE;
    3'd1:    return riscv_pkg::HALF;
    3'd4:    return riscv_pkg::BYTE_U;
    3'd5:    return riscv_pkg::HALF_U;
    default: return riscv_pkg::WORD;
  endcase
endfunction

function automatic logic [31:0] word_at(input logic [31:0] addr);
  return {ref_mem[12'(addr + 3)], ref_mem[12'(addr + 2)],
          ref_mem[12'(addr + 1)], ref_mem[12'(addr)]};
endfunction

function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic sub,
                                        input logic sra, input logic [31:0] a,
                                        input logic [31:0] b);
  case (f3)
    3'd0:    return sub ? a - b : a + b;
    3'd1:    return a << b[4:0];
    3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'd3:    return (a < b) ? 32'd1 : 32'd0;
    3'd4:    return a ^ b;
    3'd5:    return sra ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
    3'd6:    return a | b;
    default: return a & b;
  endcase
endfunction

// Runs from address zero to the self-loop; -1 if it is never reached
function automatic int run_reference(input int max_steps);
  logic [31:0]           pc;
  logic [31:0]           instr;
  logic [31:0]           npc;
  logic [31:0]           a;
  logic [31:0]           b;
  logic [31:0]           wr;
  logic [31:0]           addr;
  logic [31:0]           immi;
  logic [31:0]           imms;
  logic [31:0]           immb;
  logic [31:0]           immj;
  logic [2:0]            f3;
  logic                  wr_en;
  logic                  take;
  riscv_pkg::ldst_mode_t mode;
  store_t                s;
  for (int i = 0; i < 32; i++) begin
    ref_x[i] = '0;
  end
  pc = '0;
  for (int step = 0; step < max_steps; step++) begin
    instr = word_at(pc);
    if (instr == SELF_LOOP) begin
      return exp_stores.size();
    end
    a     = ref_x[instr[19:15]];
    b     = ref_x[instr[24:20]];
    f3    = instr[14:12];
    immi  = {{20{instr[31]}}, instr[31:20]};
    imms  = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    immb  = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    immj  = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    npc   = pc + 32'd4;
    wr    = '0;
    wr_en = 1'b1;
    case (instr[6:0])
      7'h37: wr = {instr[31:12], 12'd0};
      7'h17: wr = pc + {instr[31:12], 12'd0};
      7'h6f: begin
        wr  = pc + 32'd4;
        npc = pc + immj;
      end
      7'h67: begin
        wr  = pc + 32'd4;
        npc = (a + immi) & ~32'd1;
      end
      7'h63: begin
        wr_en = 1'b0;
        case (f3)
          3'd0:    take = a == b;
          3'd1:    take = a != b;
          3'd4:    take = $signed(a) < $signed(b);
          3'd5:    take = $signed(a) >= $signed(b);
          3'd6:    take = a < b;
          default: take = a >= b;
        endcase
        if (take) npc = pc + immb;
      end
      7'h03: wr = size_extend(word_at(a + immi), mode_of(f3));
      7'h23: begin
        wr_en  = 1'b0;
        addr   = a + imms;
        mode   = mode_of(f3);
        s.addr = addr;
        s.data = b;
        s.mode = mode;
        exp_stores.push_back(s);
        for (int k = 0; k < byte_count(mode); k++) begin
          ref_mem[12'(addr + k)] = b[8*k +: 8];
        end
      end
      7'h13: wr = alu_ref(f3, 1'b0, instr[30], a, immi);
      7'h33: wr = alu_ref(f3, instr[30], instr[30], a, b);
      default: wr_en = 1'b0;
    endcase
    if (wr_en && instr[11:7] != 5'd0) begin
      ref_x[instr[11:7]] = wr;
    end
    pc = npc;
  end
  return -1;
endfunction

`endif

// ==== bench/tb_riscv.sv ====
`timescale 1ns/1ps

module tb_riscv;

  localparam logic [31:0] RESET_PC  = 32'h0000_0000;
  localparam int          MEM_BYTES = 4096;
  localparam int          TIMEOUT   = 20000;

  logic                  clk;
  logic                  arst_n;
  logic [31:0]           rd_bus [2];
  logic [31:0]           ra_bus [2];
  riscv_pkg::ldst_mode_t rm_bus [2];
  logic                  we;
  logic [31:0]           wa;
  logic [31:0]           wd;
  riscv_pkg::ldst_mode_t wm;

  logic [7:0]  mem [MEM_BYTES];
  logic [7:0]  ref_mem [MEM_BYTES];
  logic [31:0] ref_x [32];
  int          seed;
  int          n_words;
  int          n_expected;
  int          store_count;
  int          cycles;

  typedef struct packed {
    logic [31:0]           addr;
    logic [31:0]           data;
    riscv_pkg::ldst_mode_t mode;
  } store_t;

  store_t exp_stores [$];
  store_t cur_exp;

  `include "riscv_iss.svh"

  riscv #(
    .RESET_PC (RESET_PC)
  ) u_riscv (
    .clk    (clk),
    .arst_n (arst_n),
    .rd     (rd_bus),
    .ra     (ra_bus),
    .rm     (rm_bus),
    .we     (we),
    .wa     (wa),
    .wd     (wd),
    .wm     (wm)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Combinational reads, sized and extended by mode
  always_comb begin
    for (int p = 0; p < 2; p++) begin
      rd_bus[p] = size_extend({mem[12'(ra_bus[p] + 3)], mem[12'(ra_bus[p] + 2)],
                               mem[12'(ra_bus[p] + 1)], mem[12'(ra_bus[p])]}, rm_bus[p]);
    end
  end

  always @(posedge clk) begin
    if (we) begin
      for (int k = 0; k < byte_count(wm); k++) begin
        mem[12'(wa + k)] <= wd[8*k +: 8];
      end
    end
  end

  function automatic int unsigned rnd(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  // Any register but x0 and the data base x10
  function automatic logic [4:0] pick_rd();
    logic [4:0] r;
    r = 5'(1 + rnd(30));
    if (r >= 5'd10) r = r + 5'd1;
    return r;
  endfunction

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [2:0] f3);
    return {imm[11:5], rs2, 5'd10, f3, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
  endfunction

  task automatic put_word(input logic [31:0] w);
    for (int k = 0; k < 4; k++) begin
      mem[12'(n_words * 4 + k)] = w[8*k +: 8];
    end
    n_words++;
  endtask

  task automatic add_alu();
    logic [2:0]  f3;
    logic        alt;
    logic [11:0] imm;
    f3  = 3'(rnd(8));
    alt = 1'(rnd(2));
    if (rnd(2) == 0) begin
      if (f3 != 3'd0 && f3 != 3'd5) alt = 1'b0;
      put_word(r_type({1'b0, alt, 5'd0}, 5'(rnd(32)), 5'(rnd(32)), f3, pick_rd()));
    end else begin
      if (f3 == 3'd1) imm = {7'd0, 5'(rnd(32))};
      else if (f3 == 3'd5) imm = {1'b0, alt, 5'd0, 5'(rnd(32))};
      else imm = 12'(rnd(4096));
      put_word(i_type(imm, 5'(rnd(32)), f3, pick_rd(), 7'h13));
    end
  endtask

  // Aligned offset inside the 256-byte window at x10
  task automatic add_store();
    logic [2:0] f3;
    f3 = 3'(rnd(3));
    put_word(s_type(12'(rnd(256) & ~((1 << f3) - 1)), 5'(rnd(32)), f3));
  endtask

  task automatic add_gap(input int gap);
    for (int i = 0; i < gap; i++) begin
      if (rnd(2) == 0) add_alu();
      else add_store();
    end
  endtask

  task automatic build_program();
    logic [2:0] f3;
    logic [4:0] r;
    int         gap;
    n_words = 0;
    put_word(i_type(12'h400, 5'd0, 3'd0, 5'd10, 7'h13));
    for (int i = 1; i < 32; i++) begin
      if (i != 10) put_word(i_type(12'(rnd(4096)), 5'd0, 3'd0, 5'(i), 7'h13));
    end
    while (n_words < 200) begin
      gap = 1 + int'(rnd(3));
      case (rnd(9))
        0, 1: add_alu();
        2: put_word({20'(rnd(32'hfffff)), pick_rd(), rnd(2) == 0 ? 7'h37 : 7'h17});
        3: begin
          f3 = 3'(rnd(5));
          if (f3 > 3'd2) f3 = f3 + 3'd1;
          put_word(i_type(12'(rnd(256) & ~((1 << f3[1:0]) - 1)), 5'd10, f3,
                          pick_rd(), 7'h03));
        end
        4: add_store();
        5: begin
          f3 = 3'(rnd(6));
          if (f3 > 3'd1) f3 = f3 + 3'd2;
          put_word(b_type(13'((gap + 1) * 4), 5'(rnd(32)), 5'(rnd(32)), f3));
          add_gap(gap);
        end
        6: begin
          put_word(j_type(21'((gap + 1) * 4), pick_rd()));
          add_gap(gap);
        end
        7: begin
          r = pick_rd();
          put_word({20'd0, r, 7'h17});
          put_word(i_type(12'((gap + 2) * 4), r, 3'd0, pick_rd(), 7'h67));
          add_gap(gap);
        end
        default: begin
          // Dependent chain ending in a store
          r = pick_rd();
          for (int i = 0; i < 3; i++) begin
            put_word(i_type(12'(rnd(4096)), r, 3'd0, r, 7'h13));
          end
          put_word(s_type(12'(rnd(64) * 4), r, 3'd2));
        end
      endcase
    end
    for (int i = 1; i < 32; i++) begin
      put_word(s_type(12'((i - 1) * 4), 5'(i), 3'd2));
    end
    put_word(SELF_LOOP);
  endtask

  function automatic logic [31:0] size_mask(input riscv_pkg::ldst_mode_t mode);
    case (mode)
      riscv_pkg::BYTE: return 32'h0000_00ff;
      riscv_pkg::HALF: return 32'h0000_ffff;
      default:         return 32'hffff_ffff;
    endcase
  endfunction

  always @(negedge clk) begin
    if (!arst_n) begin
      assert (we == 1'b0 && ra_bus[0] == RESET_PC) else begin
        $display("Error at %0t: during reset we=%0b ra0=%h", $time, we, ra_bus[0]);
        $display("*** FAILED ***");
        $fatal(1, "reset state wrong");
      end
    end else if (we) begin
      assert (store_count < n_expected) else begin
        $display("The core made more stores than the reference model expected");
        $display("*** FAILED ***");
        $fatal(1, "extra store");
      end
      cur_exp = exp_stores[store_count];
      store_count++;
      assert (wa == cur_exp.addr && wm == cur_exp.mode &&
              (wd & size_mask(wm)) == (cur_exp.data & size_mask(wm))) else begin
        $display("Error at %0t: store %0d addr=%h data=%h mode=%0d, expected %h %h %0d",
                 $time, store_count - 1, wa, wd, wm, cur_exp.addr, cur_exp.data,
                 cur_exp.mode);
        $display("*** FAILED ***");
        $fatal(1, "store mismatch");
      end
    end
  end

  initial begin
    arst_n      = 1'b0;
    seed        = 32'hacde4ae7;
    store_count = 0;
    cycles      = 0;
    // Fill pattern mixes all address bits
    for (int i = 0; i < MEM_BYTES; i++) begin
      mem[i] = 8'(i ^ (i >> 8) ^ (i >> 4) * 8'h5b);
    end
    build_program();
    for (int i = 0; i < MEM_BYTES; i++) begin
      ref_mem[i] = mem[i];
    end
    n_expected = run_reference(100000);
    if (n_expected < 0) begin
      $display("The reference model never reached the final self-loop");
      $display("*** FAILED ***");
      $fatal(1, "bad program");
    end
    repeat (16) @(posedge clk);
    arst_n <= 1'b1;
    while (store_count < n_expected && cycles < TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    if (store_count == n_expected) begin
      // Younger instructions reach the bus within the pipeline depth
      repeat (4) @(posedge clk);
      $display("*** PASSED ***");
      $finish;
    end else begin
      $display("The stores stopped coming: %0d of %0d seen", store_count, n_expected);
      $display("*** FAILED ***");
      $fatal(1, "timeout");
    end
  end

endmodule

// ==== design/riscv.sv ====
`timescale 1ns/1ps

module riscv #(
  parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
  input  logic                         clk,
  input  logic                         arst_n,

  // Memory bus; port 0 fetches, port 1 loads
  input  logic                  [31:0] rd [2],
  output logic                  [31:0] ra [2],
  output riscv_pkg::ldst_mode_t        rm [2],
  output logic                         we,
  output logic                  [31:0] wa,
  output logic                  [31:0] wd,
  output riscv_pkg::ldst_mode_t        wm
);

  logic [31:0]           instr;
  logic [31:0]           instr_pc;
  logic                  instr_valid;
  logic                  redirect;
  logic [31:0]           target;
  logic [4:0]            rs1;
  logic [4:0]            rs2;
  logic [31:0]           rdata1;
  logic [31:0]           rdata2;
  riscv_pkg::result_t    result;
  logic                  rf_we;
  logic [4:0]            rf_waddr;
  logic [31:0]           rf_wdata;

  riscv_fetch #(
    .RESET_PC (RESET_PC)
  ) u_fetch (
    .clk         (clk),
    .arst_n      (arst_n),
    .redirect    (redirect),
    .target      (target),
    .fetch_addr  (ra[0]),
    .fetch_instr (rd[0]),
    .instr       (instr),
    .instr_pc    (instr_pc),
    .instr_valid (instr_valid)
  );

  assign rm[0] = riscv_pkg::WORD;

  riscv_execute u_execute (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr       (instr),
    .instr_pc    (instr_pc),
    .instr_valid (instr_valid),
    .rs1         (rs1),
    .rs2         (rs2),
    .rdata1      (rdata1),
    .rdata2      (rdata2),
    .fwd         (result),
    .load_addr   (ra[1]),
    .load_mode   (rm[1]),
    .load_data   (rd[1]),
    .redirect    (redirect),
    .target      (target),
    .result      (result)
  );

  riscv_regfile u_regfile (
    .clk    (clk),
    .arst_n (arst_n),
    .rs1    (rs1),
    .rs2    (rs2),
    .rdata1 (rdata1),
    .rdata2 (rdata2),
    .we     (rf_we),
    .waddr  (rf_waddr),
    .wdata  (rf_wdata)
  );

  riscv_commit u_commit (
    .result   (result),
    .rf_we    (rf_we),
    .rf_waddr (rf_waddr),
    .rf_wdata (rf_wdata),
    .we       (we),
    .wa       (wa),
    .wd       (wd),
    .wm       (wm)
  );

endmodule

// ==== design/riscv_commit.sv ====
`timescale 1ns/1ps

module riscv_commit (
  input  riscv_pkg::result_t           result,
  output logic                         rf_we,
  output logic                  [4:0]  rf_waddr,
  output logic                  [31:0] rf_wdata,
  output logic                         we,
  output logic                  [31:0] wa,
  output logic                  [31:0] wd,
  output riscv_pkg::ldst_mode_t        wm
);

  // Bubbles never touch architectural state
  assign rf_we    = result.valid && result.writes_rd && result.rd != 5'd0;
  assign rf_waddr = result.rd;
  assign rf_wdata = result.value;

  // Memory takes the low bytes of wd per wm
  assign we = result.valid && result.is_store;
  assign wa = result.store_addr;
  assign wd = result.store_data;
  assign wm = result.mem_mode;

endmodule

// ==== design/riscv_execute.sv ====
`timescale 1ns/1ps

module riscv_execute (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic                  [31:0] instr,
  input  logic                  [31:0] instr_pc,
  input  logic                         instr_valid,
  output logic                  [4:0]  rs1,
  output logic                  [4:0]  rs2,
  input  logic                  [31:0] rdata1,
  input  logic                  [31:0] rdata2,
  input  riscv_pkg::result_t           fwd,
  output logic                  [31:0] load_addr,
  output riscv_pkg::ldst_mode_t        load_mode,
  input  logic                  [31:0] load_data,
  output logic                         redirect,
  output logic                  [31:0] target,
  output riscv_pkg::result_t           result
);

  riscv_pkg::decoded_t dec;
  riscv_pkg::result_t  next;
  riscv_pkg::result_t  res_q;
  logic                res_valid;
  logic [31:0]         src1;
  logic [31:0]         src2;
  logic [31:0]         op_a;
  logic [31:0]         op_b;
  logic [31:0]         alu_out;
  logic                taken;

  riscv_decode u_decode (
    .instr   (instr),
    .pc      (instr_pc),
    .valid   (instr_valid),
    .decoded (dec)
  );

  assign rs1 = dec.rs1;
  assign rs2 = dec.rs2;

  function automatic logic [31:0] forward(input logic [4:0] rs, input logic [31:0] rf_val,
                                          input riscv_pkg::result_t res);
    if (res.valid && res.writes_rd && res.rd != 5'd0 && res.rd == rs) begin
      return res.value;
    end
    return rf_val;
  endfunction

  assign src1 = forward(dec.rs1, rdata1, fwd);
  assign src2 = forward(dec.rs2, rdata2, fwd);
  assign op_a = dec.a_is_pc ? dec.pc : src1;
  assign op_b = dec.b_is_imm ? dec.imm : src2;

  always_comb begin
    case (dec.alu_op)
      riscv_pkg::ADD:  alu_out = op_a + op_b;
      riscv_pkg::SUB:  alu_out = op_a - op_b;
      riscv_pkg::SLL:  alu_out = op_a << op_b[4:0];
      riscv_pkg::SLT:  alu_out = {31'd0, $signed(op_a) < $signed(op_b)};
      riscv_pkg::SLTU: alu_out = {31'd0, op_a < op_b};
      riscv_pkg::XOR:  alu_out = op_a ^ op_b;
      riscv_pkg::SRL:  alu_out = op_a >> op_b[4:0];
      riscv_pkg::SRA:  alu_out = $signed(op_a) >>> op_b[4:0];
      riscv_pkg::OR:   alu_out = op_a | op_b;
      riscv_pkg::AND:  alu_out = op_a & op_b;
      default:         alu_out = op_b;
    endcase
  end

  always_comb begin
    case (dec.br_cond)
      riscv_pkg::EQ:     taken = src1 == src2;
      riscv_pkg::NE:     taken = src1 != src2;
      riscv_pkg::LT:     taken = $signed(src1) < $signed(src2);
      riscv_pkg::GE:     taken = $signed(src1) >= $signed(src2);
      riscv_pkg::LTU:    taken = src1 < src2;
      riscv_pkg::GEU:    taken = src1 >= src2;
      riscv_pkg::ALWAYS: taken = 1'b1;
      default:           taken = 1'b0;
    endcase
  end

  assign redirect = dec.valid && taken;
  assign target   = dec.is_jalr ? ((src1 + dec.imm) & ~32'd1) : (dec.pc + dec.imm);

  // Memory sizes and extends the load itself
  assign load_addr = alu_out;
  assign load_mode = dec.mem_mode;

  always_comb begin
    next.valid     = dec.valid;
    next.rd        = dec.rd;
    next.writes_rd = dec.writes_rd;
    if (dec.is_load) begin
      next.value = load_data;
    end else if (dec.br_cond == riscv_pkg::ALWAYS) begin
      next.value = dec.pc + 32'd4;
    end else begin
      next.value = alu_out;
    end
    next.is_store   = dec.is_store;
    next.store_addr = alu_out;
    next.store_data = src2;
    next.mem_mode   = dec.mem_mode;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= next.valid;
    end
  end

  always_ff @(posedge clk) begin
    res_q <= next;
  end

  always_comb begin
    result       = res_q;
    result.valid = res_valid;
  end

endmodule

// ==== design/riscv_regfile.sv ====
`timescale 1ns/1ps

module riscv_regfile (
  input  logic        clk,
  input  logic        arst_n,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  output logic [31:0] rdata1,
  output logic [31:0] rdata2,
  input  logic        we,
  input  logic [4:0]  waddr,
  input  logic [31:0] wdata
);

  // x0 has no storage
  logic [31:0] regs [31:1];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != 5'd0) begin
      regs[waddr] <= wdata;
    end
  end

  // Write-through so a same-cycle writeback is seen
  always_comb begin
    if (rs1 == 5'd0) begin
      rdata1 = '0;
    end else if (we && rs1 == waddr) begin
      rdata1 = wdata;
    end else begin
      rdata1 = regs[rs1];
    end
  end

  always_comb begin
    if (rs2 == 5'd0) begin
      rdata2 = '0;
    end else if (we && rs2 == waddr) begin
      rdata2 = wdata;
    end else begin
      rdata2 = regs[rs2];
    end
  end

endmodule

// ==== design/riscv_decode.sv ====
`timescale 1ns/1ps

module riscv_decode (
  input  logic                 [31:0] instr,
  input  logic                 [31:0] pc,
  input  logic                        valid,
  output riscv_pkg::decoded_t         decoded
);

  riscv_pkg::opcode_t opcode;
  logic [2:0]         funct3;
  logic               alt;
  logic [31:0]        imm_i;
  logic [31:0]        imm_s;
  logic [31:0]        imm_b;
  logic [31:0]        imm_u;
  logic [31:0]        imm_j;
  logic               known;

  assign opcode = riscv_pkg::opcode_t'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign alt    = instr[30];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'd0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // Shared by OP and OP_IMM; alt selects SUB only for register ops
  function automatic riscv_pkg::alu_op_t alu_sel(input logic [2:0] f3, input logic sub_ok,
                                                 input logic sra);
    case (f3)
      3'b000: begin
        if (sub_ok) return riscv_pkg::SUB;
        return riscv_pkg::ADD;
      end
      3'b001: return riscv_pkg::SLL;
      3'b010: return riscv_pkg::SLT;
      3'b011: return riscv_pkg::SLTU;
      3'b100: return riscv_pkg::XOR;
      3'b101: begin
        if (sra) return riscv_pkg::SRA;
        return riscv_pkg::SRL;
      end
      3'b110: return riscv_pkg::OR;
      default: return riscv_pkg::AND;
    endcase
  endfunction

  always_comb begin
    decoded          = '0;
    known            = 1'b1;
    decoded.rs1      = instr[19:15];
    decoded.rs2      = instr[24:20];
    decoded.rd       = instr[11:7];
    decoded.pc       = pc;
    decoded.alu_op   = riscv_pkg::ADD;
    decoded.br_cond  = riscv_pkg::NONE;
    decoded.mem_mode = riscv_pkg::WORD;
    case (opcode)
      riscv_pkg::LUI: begin
        decoded.imm       = imm_u;
        decoded.alu_op    = riscv_pkg::PASS_B;
        decoded.b_is_imm  = 1'b1;
        decoded.writes_rd = 1'b1;
      end
      riscv_pkg::AUIPC: begin
        decoded.imm       = imm_u;
        decoded.a_is_pc   = 1'b1;
        decoded.b_is_imm  = 1'b1;
        decoded.writes_rd = 1'b1;
      end
      riscv_pkg::JAL: begin
        decoded.imm       = imm_j;
        decoded.br_cond   = riscv_pkg::ALWAYS;
        decoded.writes_rd = 1'b1;
      end
      riscv_pkg::JALR: begin
        decoded.imm       = imm_i;
        decoded.br_cond   = riscv_pkg::ALWAYS;
        decoded.is_jalr   = 1'b1;
        decoded.writes_rd = 1'b1;
      end
      riscv_pkg::BRANCH: begin
        decoded.imm = imm_b;
        case (funct3)
          3'b000:  decoded.br_cond = riscv_pkg::EQ;
          3'b001:  decoded.br_cond = riscv_pkg::NE;
          3'b100:  decoded.br_cond = riscv_pkg::LT;
          3'b101:  decoded.br_cond = riscv_pkg::GE;
          3'b110:  decoded.br_cond = riscv_pkg::LTU;
          3'b111:  decoded.br_cond = riscv_pkg::GEU;
          default: known = 1'b0;
        endcase
      end
      riscv_pkg::LOAD: begin
        decoded.imm       = imm_i;
        decoded.b_is_imm  = 1'b1;
        decoded.is_load   = 1'b1;
        decoded.writes_rd = 1'b1;
        case (funct3)
          3'b000:  decoded.mem_mode = riscv_pkg::BYTE;
          3'b001:  decoded.mem_mode = riscv_pkg::HALF;
          3'b010:  decoded.mem_mode = riscv_pkg::WORD;
          3'b100:  decoded.mem_mode = riscv_pkg::BYTE_U;
          3'b101:  decoded.mem_mode = riscv_pkg::HALF_U;
          default: known = 1'b0;
        endcase
      end
      riscv_pkg::STORE: begin
        decoded.imm      = imm_s;
        decoded.b_is_imm = 1'b1;
        decoded.is_store = 1'b1;
        case (funct3)
          3'b000:  decoded.mem_mode = riscv_pkg::BYTE;
          3'b001:  decoded.mem_mode = riscv_pkg::HALF;
          3'b010:  decoded.mem_mode = riscv_pkg::WORD;
          default: known = 1'b0;
        endcase
      end
      riscv_pkg::OP_IMM: begin
        decoded.imm       = imm_i;
        decoded.b_is_imm  = 1'b1;
        decoded.writes_rd = 1'b1;
        decoded.alu_op    = alu_sel(funct3, 1'b0, alt);
      end
      riscv_pkg::OP: begin
        decoded.writes_rd = 1'b1;
        decoded.alu_op    = alu_sel(funct3, alt, alt);
      end
      default: known = 1'b0;
    endcase
    decoded.valid = valid && known;
  end

endmodule

// ==== design/riscv_fetch.sv ====
`timescale 1ns/1ps

module riscv_fetch #(
  parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        redirect,
  input  logic [31:0] target,
  output logic [31:0] fetch_addr,
  input  logic [31:0] fetch_instr,
  output logic [31:0] instr,
  output logic [31:0] instr_pc,
  output logic        instr_valid
);

  logic [31:0] pc;

  assign fetch_addr = pc;

  // Word fetched during a redirect is on the wrong path
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc          <= RESET_PC;
      instr_valid <= 1'b0;
    end else begin
      if (redirect) begin
        pc <= target;
      end else begin
        pc <= pc + 32'd4;
      end
      instr_valid <= !redirect;
    end
  end

  always_ff @(posedge clk) begin
    instr    <= fetch_instr;
    instr_pc <= pc;
  end

endmodule

// ==== design/riscv_pkg.sv ====
package riscv_pkg;

  // Access size and extension for a bus read or write
  typedef enum logic [2:0] {
    BYTE,
    HALF,
    WORD,
    BYTE_U,
    HALF_U
  } ldst_mode_t;

  // RV32I major opcodes
  typedef enum logic [6:0] {
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    OP_IMM = 7'b0010011,
    OP     = 7'b0110011
  } opcode_t;

  typedef enum logic [3:0] {
    ADD,
    SUB,
    SLL,
    SLT,
    SLTU,
    XOR,
    SRL,
    SRA,
    OR,
    AND,
    PASS_B
  } alu_op_t;

  typedef enum logic [2:0] {
    NONE,
    EQ,
    NE,
    LT,
    GE,
    LTU,
    GEU,
    ALWAYS
  } br_cond_t;

  typedef struct packed {
    logic        valid;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] imm;
    alu_op_t     alu_op;
    logic        a_is_pc;
    logic        b_is_imm;
    br_cond_t    br_cond;
    logic        is_jalr;
    logic        is_load;
    logic        is_store;
    ldst_mode_t  mem_mode;
    logic        writes_rd;
    logic [31:0] pc;
  } decoded_t;

  // Outcome of one instruction, held between execute and commit
  typedef struct packed {
    logic        valid;
    logic [4:0]  rd;
    logic        writes_rd;
    logic [31:0] value;
    logic        is_store;
    logic [31:0] store_addr;
    logic [31:0] store_data;
    ldst_mode_t  mem_mode;
  } result_t;

endpackage
